/* Bender.yml */
package:
  name: portArb

sources:
  - include_dirs:
      - hw
    files:
      - hw/portArbPkg.sv
      - hw/pendIf.sv
      - hw/grantIf.sv
      - hw/requestLatch.sv
      - hw/roundRobinPriority.sv
      - hw/grantOutput.sv
      - hw/portArbiterTop.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/portArbTb.sv

/* dv/arbVectors.txt */
// Header 1,test,mode,00000,nStim,nExp | stimulus 2,validMask,00,data3..data0
// Expected 3,00000000,port,data | modes 0 ready, 1 random gaps, 2 stall, 3 reset first
110000000606
240000210000
210000000005
28003c000000
220000001700
2400002a0000
21000000000e
300000000221
300000000005
30000000033c
300000000117
30000000022a
30000000000e
120000000104
2f00b3b2b1b0
3000000002b2
3000000003b3
3000000000b0
3000000001b1
131000000208
2f00c3c2c1c0
2f00d3d2d1d0
3000000002c2
3000000003c3
3000000000c0
3000000001c1
3000000002d2
3000000003d3
3000000000d0
3000000001d1
142000000303
2800e1000000
2800e2000000
2800e3000000
3000000003e1
3000000003e2
3000000003e3
153000000104
2f00f3f2f1f0
3000000000f0
3000000001f1
3000000002f2
3000000003f3
000000000000

/* dv/portArbTb.sv */
`timescale 1ns/100ps

`include "portArb_cfg.svh"

module portArbTb;
    import portArbPkg::*;

    localparam int PortCount = `ARB_PORT_COUNT;

    logic                 clk;
    logic                 arstN;
    logic [PortCount-1:0] inValid;
    payloadT              inData [PortCount];
    logic [PortCount-1:0] inReady;
    logic                 outValid;
    logic                 outReady;
    portIdxT              outPort;
    payloadT              outData;

    // Vector words with the record tag in the top hex digit
    logic [47:0]          vecMem [64];
    // Expected port and data of the running test
    logic [15:0]          expQ [$];
    // Input handshakes seen at the last rising edge
    logic [PortCount-1:0] takenVec;
    // Output was stalled at the last rising edge
    logic                 holdPrev;
    portIdxT              prevPort;
    payloadT              prevData;
    logic [31:0]          lcgState;
    int                   testErrs;
    int                   passCount;
    int                   failCount;
    int                   outSeen;
    int                   cycleCount;
    int                   cycleLimit;

    portArbiterTop dut0 (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inData   (inData),
        .inReady  (inReady),
        .outValid (outValid),
        .outReady (outReady),
        .outPort  (outPort),
        .outData  (outData)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic compareValues(input string name, input logic [31:0] expVal,
                                 input logic [31:0] gotVal);
        if (gotVal !== expVal) begin
            $display("ERR %s expected %0h got %0h", name, expVal, gotVal);
            testErrs++;
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        arstN   = 1'b0;
        inValid = '0;
        repeat (8) @(negedge clk);
        arstN = 1'b1;
    endtask

    // One falling edge, drop taken requests, then pick outReady
    // Mode 1 gaps ready at random, mode 2 stalls
    task automatic nextCycle(input logic [3:0] mode);
        @(negedge clk);
        inValid = inValid & ~takenVec;
        if (mode == 4'd1) begin
            lcgState = nextRandom(lcgState);
            outReady = lcgState[16];
        end else begin
            outReady = (mode != 4'd2);
        end
    endtask

    // Output checker and stall stability
    always @(posedge clk) begin
        takenVec = inValid & inReady;
        if (!arstN) begin
            holdPrev = 1'b0;
        end else begin
            if (holdPrev) begin
                compareValues("outValid", 1, outValid);
                compareValues("outPort", prevPort, outPort);
                compareValues("outData", prevData, outData);
            end
            if (outValid && outReady) begin
                outSeen++;
                if (expQ.size() == 0) begin
                    $display("unexpected output from port %0d", outPort);
                    testErrs++;
                end else begin
                    compareValues("outPort", expQ[0][15:8], outPort);
                    compareValues("outData", expQ[0][7:0], outData);
                    void'(expQ.pop_front());
                end
            end
            holdPrev = outValid && !outReady;
            prevPort = outPort;
            prevData = outData;
        end
    end

    // Header, stimulus records, then expected outputs
    task automatic runTest(inout int idx);
        logic [47:0] hdr;
        logic [47:0] word;
        logic [3:0]  mode;
        int          nStim;
        int          nExp;
        hdr   = vecMem[idx];
        mode  = hdr[39:36];
        nStim = hdr[15:8];
        nExp  = hdr[7:0];
        idx++;
        testErrs = 0;
        outSeen  = 0;
        expQ.delete();
        for (int e = 0; e < nExp; e++) begin
            expQ.push_back(vecMem[idx+nStim+e][15:0]);
        end
        // Mid-run reset must clear the pipeline and the pointer
        if (mode == 4'd3) begin
            // Fill every buffer and the output register behind a stall
            @(negedge clk);
            outReady = 1'b0;
            inValid  = '1;
            repeat (3) @(negedge clk);
            compareValues("outValid", 1, outValid);
            applyReset();
            compareValues("outValid", 0, outValid);
            compareValues("inReady", {PortCount{1'b1}}, inReady);
        end
        for (int s = 0; s < nStim; s++) begin
            word = vecMem[idx+s];
            nextCycle(mode);
            // Held ports keep valid until the latch takes them
            while ((inValid & word[43:40]) != '0) begin
                nextCycle(mode);
            end
            for (int p = 0; p < PortCount; p++) begin
                if (word[40+p]) begin
                    inValid[p] = 1'b1;
                    inData[p]  = word[8*p +: 8];
                end
            end
        end
        idx += nStim + nExp;
        if (mode == 4'd2) begin
            nextCycle(mode);
            // Full buffer behind a stalled output
            compareValues("inReady", 0, inReady & inValid);
            compareValues("outValid", 1, outValid);
            mode = 4'd0;
            while (inValid != '0) begin
                nextCycle(mode);
            end
            if (outSeen == 0) begin
                $display("port refilled before its earlier request was output");
                testErrs++;
            end
        end
        while (expQ.size() != 0 || inValid != '0) begin
            nextCycle(mode);
        end
        if (testErrs == 0) begin
            passCount++;
            $display("test %0d passed", hdr[43:40]);
        end else begin
            failCount++;
            $display("test %0d failed with %0d errors", hdr[43:40], testErrs);
        end
    endtask

    initial begin
        int vecIdx;
        int stimTotal;
        arstN     = 1'b0;
        inValid   = '0;
        inData    = '{default: '0};
        outReady  = 1'b0;
        holdPrev  = 1'b0;
        lcgState  = 32'h73fc;
        passCount = 0;
        failCount = 0;
        stimTotal = 0;
        $readmemh("dv/arbVectors.txt", vecMem);
        for (int i = 0; i < 64; i++) begin
            if (vecMem[i][47:44] === 4'h2) begin
                stimTotal++;
            end
        end
        cycleLimit = 4 * stimTotal + 200;
        applyReset();
        vecIdx = 0;
        while (vecMem[vecIdx][47:44] === 4'h1) begin
            runTest(vecIdx);
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0 && passCount > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Run limit from the stimulus length
    initial begin
        cycleCount = 0;
        @(posedge clk);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("run stopped after %0d cycles without finishing", cycleCount);
        $display("sim failed");
        $finish;
    end

endmodule

/* hw/grantIf.sv */
`timescale 1ns/100ps

interface grantIf;
    import portArbPkg::*;

    // Valid/ready transfer when both are high at an edge
    logic    grantValid;
    logic    grantReady;
    // Winner and its payload
    portIdxT grantPort;
    payloadT grantData;

    // Arbiter side
    modport arb (
        output grantValid,
        output grantPort,
        output grantData,
        input  grantReady
    );

    // Output register side
    modport out (
        input  grantValid,
        input  grantPort,
        input  grantData,
        output grantReady
    );

endinterface

/* hw/grantOutput.sv */
`timescale 1ns/100ps

module grantOutput (
    input  logic                clk,
    input  logic                arstN,
    input  logic                outReady,
    output logic                outValid,
    output portArbPkg::portIdxT outPort,
    output portArbPkg::payloadT outData,
    grantIf.out                 grant
);
    import portArbPkg::*;

    outStateE state;
    // Grant moves into the register this edge
    logic     takeGrant;

    // Accept when empty or when the held grant leaves this edge
    assign grant.grantReady = (state == OUT_EMPTY) || outReady;
    assign takeGrant        = grant.grantValid && grant.grantReady;
    assign outValid         = (state == OUT_HOLD);

    // Holding FSM
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= OUT_EMPTY;
        end else begin
            case (state)
                OUT_EMPTY: begin
                    if (grant.grantValid) begin
                        state <= OUT_HOLD;
                    end
                end
                OUT_HOLD: begin
                    // Drained with nothing behind it
                    if (outReady && !grant.grantValid) begin
                        state <= OUT_EMPTY;
                    end
                end
                default: state <= OUT_EMPTY;
            endcase
        end
    end

    // Winner register
    always_ff @(posedge clk) begin
        if (takeGrant) begin
            outPort <= grant.grantPort;
            outData <= grant.grantData;
        end
    end

    // Output holds steady under back-pressure
    holdStableA: assert property (
        @(posedge clk) disable iff (!arstN)
        outValid && !outReady |=> outValid && $stable(outPort) && $stable(outData)
    ) else $error("output changed while stalled");

endmodule

/* hw/pendIf.sv */
`timescale 1ns/100ps

`include "portArb_cfg.svh"

interface pendIf;
    import portArbPkg::*;

    // One bit per port holding a request
    logic [`ARB_PORT_COUNT-1:0] pendVec;
    // Buffered payload per port
    payloadT                    pendData [`ARB_PORT_COUNT];
    // One-hot port to drop while clrEn is high
    logic [`ARB_PORT_COUNT-1:0] clrVec;
    logic                       clrEn;

    // Request buffers side
    modport latch (
        output pendVec,
        output pendData,
        input  clrVec,
        input  clrEn
    );

    // Arbiter side
    modport arb (
        input  pendVec,
        input  pendData,
        output clrVec,
        output clrEn
    );

endinterface

/* hw/portArbPkg.sv */
`include "portArb_cfg.svh"

package portArbPkg;

    // Port number, also used for the priority pointer
    typedef logic [`ARB_IDX_WIDTH-1:0] portIdxT;

    // One request's data word
    typedef logic [`ARB_DATA_WIDTH-1:0] payloadT;

    // Output register stage
    // EMPTY means nothing held, HOLD means a grant waits on outReady
    typedef enum logic {
        OUT_EMPTY = 1'b0,
        OUT_HOLD  = 1'b1
    } outStateE;

endpackage

/* hw/portArb_cfg.svh */
`ifndef PORTARB_CFG_SVH
`define PORTARB_CFG_SVH

// Number of requester ports as a power of two
`define ARB_PORT_COUNT 4

// Bits needed to name one port
`define ARB_IDX_WIDTH 2

// Request payload width
`define ARB_DATA_WIDTH 8

`endif

/* hw/portArbiterTop.sv */
`timescale 1ns/100ps

`include "portArb_cfg.svh"

module portArbiterTop (
    input  logic                       clk,
    input  logic                       arstN,
    // Per-port request channels
    input  logic [`ARB_PORT_COUNT-1:0] inValid,
    input  portArbPkg::payloadT        inData [`ARB_PORT_COUNT],
    output logic [`ARB_PORT_COUNT-1:0] inReady,
    // Granted request channel
    output logic                       outValid,
    input  logic                       outReady,
    output portArbPkg::portIdxT        outPort,
    output portArbPkg::payloadT        outData
);

    // Latch to arbiter
    pendIf  pendBus ();
    // Arbiter to output register
    grantIf grantBus ();

    // Stage 1 holds one buffer per port
    requestLatch latch0 (
        .clk     (clk),
        .arstN   (arstN),
        .inValid (inValid),
        .inData  (inData),
        .inReady (inReady),
        .pend    (pendBus.latch)
    );

    // Stage 2 picks round-robin
    roundRobinPriority arb0 (
        .clk   (clk),
        .arstN (arstN),
        .pend  (pendBus.arb),
        .grant (grantBus.arb)
    );

    // Stage 3 registers the output under back-pressure
    grantOutput out0 (
        .clk      (clk),
        .arstN    (arstN),
        .outReady (outReady),
        .outValid (outValid),
        .outPort  (outPort),
        .outData  (outData),
        .grant    (grantBus.out)
    );

endmodule

/* hw/requestLatch.sv */
`timescale 1ns/100ps

`include "portArb_cfg.svh"

module requestLatch (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic [`ARB_PORT_COUNT-1:0] inValid,
    input  portArbPkg::payloadT        inData [`ARB_PORT_COUNT],
    output logic [`ARB_PORT_COUNT-1:0] inReady,
    pendIf.latch                       pend
);
    import portArbPkg::*;

    localparam int PortCount = `ARB_PORT_COUNT;

    // Buffer occupancy, one flag per port
    logic [PortCount-1:0] fullVec;
    // Handshake hits this cycle
    logic [PortCount-1:0] loadVec;
    // Held payloads
    payloadT              bufData [PortCount];

    // Ready only while the buffer is empty
    // so a cleared port refills one edge later at the earliest
    assign inReady = ~fullVec;
    assign loadVec = inValid & inReady;

    // Occupancy flags
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fullVec <= '0;
        end else begin
            for (int i = 0; i < PortCount; i++) begin
                // Clear and load never hit the same port
                if (pend.clrEn && pend.clrVec[i]) begin
                    fullVec[i] <= 1'b0;
                end else if (loadVec[i]) begin
                    fullVec[i] <= 1'b1;
                end
            end
        end
    end

    // Payload capture on accept
    always_ff @(posedge clk) begin
        for (int i = 0; i < PortCount; i++) begin
            if (loadVec[i]) begin
                bufData[i] <= inData[i];
            end
        end
    end

    // Pending view for the arbiter
    assign pend.pendVec  = fullVec;
    assign pend.pendData = bufData;

    // Arbiter may only drop one port, and only one that holds a request
    clrOnlyFullA: assert property (
        @(posedge clk) disable iff (!arstN)
        pend.clrEn |-> ($onehot(pend.clrVec) && ((pend.clrVec & ~fullVec) == '0))
    ) else $error("clrVec names an empty port or is not one-hot");

endmodule

/* hw/roundRobinPriority.sv */
`timescale 1ns/100ps

`include "portArb_cfg.svh"

module roundRobinPriority (
    input logic clk,
    input logic arstN,
    pendIf.arb  pend,
    grantIf.arb grant
);
    import portArbPkg::*;

    localparam int PortCount = `ARB_PORT_COUNT;
    localparam int IdxWidth  = `ARB_IDX_WIDTH;

    // Priority pointer, search starts here
    portIdxT                prioPtr;
    // Pending vector repeated so a right shift wraps
    logic [2*PortCount-1:0] doubledVec;
    logic [2*PortCount-1:0] shiftedWide;
    // Pending ports relative to the pointer
    logic [PortCount-1:0]   rotatedVec;
    // One-hot first pending port after the pointer
    logic [PortCount-1:0]   lowestBit;
    // Per index bit, which one-hot positions set it
    logic [PortCount-1:0]   bitMask [IdxWidth];
    // Winner offset from the pointer
    portIdxT                scanIdx;
    // Grant accepted by the output stage
    logic                   grantFire;

    // Rotate pending vector right by the pointer
    assign doubledVec  = {pend.pendVec, pend.pendVec};
    assign shiftedWide = doubledVec >> prioPtr;
    assign rotatedVec  = shiftedWide[PortCount-1:0];

    // Two's complement trick keeps only the lowest set bit
    assign lowestBit = rotatedVec & (~rotatedVec + 1'b1);

    // One-hot to index encoder
    for (genvar maskIdx = 0; maskIdx < IdxWidth; maskIdx++) begin : maskScan
        for (genvar bitIdx = 0; bitIdx < PortCount; bitIdx++) begin : bitScan
            // Position bitIdx contributes to index bit maskIdx
            assign bitMask[maskIdx][bitIdx] = ((bitIdx >> maskIdx) % 2) == 1;
        end
        // OR-reduce the masked one-hot
        assign scanIdx[maskIdx] = |(lowestBit & bitMask[maskIdx]);
    end

    // Undo the rotation with an add that wraps for power-of-two counts
    assign grant.grantPort  = scanIdx + prioPtr;
    assign grant.grantData  = pend.pendData[grant.grantPort];
    // Valid from pending state only, never from ready
    assign grant.grantValid = |pend.pendVec;

    assign grantFire = grant.grantValid && grant.grantReady;

    // Drop the winner's buffer on the accepting edge
    assign pend.clrEn  = grantFire;
    assign pend.clrVec = grantFire ? ({{(PortCount-1){1'b0}}, 1'b1} << grant.grantPort) : '0;

    // Pointer steps once per serviced port
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prioPtr <= '0;
        end else if (grantFire) begin
            prioPtr <= prioPtr + 1'b1;
        end
    end

    // Winner must hold a request in the latch stage
    grantPendingA: assert property (
        @(posedge clk) disable iff (!arstN)
        grant.grantValid |-> pend.pendVec[grant.grantPort]
    ) else $error("granted port %0d is not pending", grant.grantPort);

endmodule

/* tb.f */
+incdir+hw
hw/portArbPkg.sv
hw/pendIf.sv
hw/grantIf.sv
hw/requestLatch.sv
hw/roundRobinPriority.sv
hw/grantOutput.sv
hw/portArbiterTop.sv
dv/portArbTb.sv
